// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_upsample_chain -f files.f -Mdir obj_dir
	@out=$$(./obj_dir/Vtb_upsample_chain); echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// File: files.f
rtl/audio_pkg.sv
rtl/mult_if.sv
rtl/mult_share.sv
rtl/sample_prefetch.sv
rtl/upsample_stage.sv
rtl/rate_output_select.sv
rtl/upsample_chain.sv
testbench/tb_upsample_chain.sv

// File: rtl/audio_pkg.sv
`default_nettype none

package audio_pkg;

    localparam int NUM_CH = 2;  // Left and right

    typedef logic signed [23:0] sample_t;
    typedef logic signed [15:0] coef_t;   // Q1.15
    typedef logic [NUM_CH-1:0]  chan_mask_t;  // Bit 0 left, bit 1 right

    // Code value equals the number of 2x stages in use
    typedef enum logic [1:0] {
        RATE_192 = 2'd0,
        RATE_96  = 2'd1,
        RATE_48  = 2'd2
    } rate_e;

endpackage

`default_nettype wire

// File: rtl/mult_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mult_if;
    import audio_pkg::*;

    logic    grant;
    sample_t mpcand;  // Zero outside the grant window
    coef_t   mplier;
    sample_t mprod;   // Two cycles after the operands

    modport stage (input grant, output mpcand, output mplier, input mprod);
    modport share (output grant, input mpcand, input mplier, output mprod);

endinterface

`default_nettype wire

// File: rtl/mult_share.sv
`timescale 1ns/1ps
`default_nettype none

module mult_share #(
    parameter int NUM_STAGES  = 2,
    parameter int SLOT_CYCLES = 16
) (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  audio_pkg::chan_mask_t out_pop_i,
    mult_if.share                mult [NUM_STAGES]
);
    import audio_pkg::*;

    localparam int CNT_W = $clog2(SLOT_CYCLES);
    localparam logic [NUM_STAGES-1:0] LAST_GRANT = NUM_STAGES'(1) << (NUM_STAGES - 1);

    logic [CNT_W-1:0]      slot_cnt_q;
    logic [NUM_STAGES-1:0] grant_q;

    sample_t cand_arr  [NUM_STAGES];
    coef_t   plier_arr [NUM_STAGES];
    sample_t cand_or;
    coef_t   plier_or;

    sample_t            cand_q;
    coef_t              plier_q;
    logic signed [39:0] prod_full;
    sample_t            prod_q;

    // Windows run from the stage nearest the output towards the first,
    // then rotate back to the last one
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            slot_cnt_q <= '0;
            grant_q    <= '0;
        end else if (|out_pop_i) begin
            slot_cnt_q <= '0;
            grant_q    <= LAST_GRANT;
        end else if (|grant_q) begin
            if (slot_cnt_q == CNT_W'(SLOT_CYCLES - 1)) begin
                slot_cnt_q <= '0;
                grant_q    <= grant_q[0] ? LAST_GRANT : (grant_q >> 1);
            end else begin
                slot_cnt_q <= slot_cnt_q + 1'b1;
            end
        end
    end

    for (genvar i = 0; i < NUM_STAGES; i++) begin : g_port
        assign mult[i].grant = grant_q[i];
        assign mult[i].mprod = prod_q;
        assign cand_arr[i]   = mult[i].mpcand;
        assign plier_arr[i]  = mult[i].mplier;
    end

    // Idle stages drive zero, so a plain OR merges the operands
    always_comb begin
        cand_or  = '0;
        plier_or = '0;
        for (int i = 0; i < NUM_STAGES; i++) begin
            cand_or  = cand_or | cand_arr[i];
            plier_or = plier_or | plier_arr[i];
        end
    end

    assign prod_full = cand_q * plier_q;

    always_ff @(posedge clk) begin
        cand_q  <= cand_or;
        plier_q <= plier_or;
        prod_q  <= prod_full[38:15];  // Q1.15 scaling back to sample range
    end

endmodule

`default_nettype wire

// File: rtl/rate_output_select.sv
`timescale 1ns/1ps
`default_nettype none

module rate_output_select #(
    parameter int NUM_STAGES = 2
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  audio_pkg::rate_e      rate_i,
    input  audio_pkg::chan_mask_t pop_i,
    output audio_pkg::sample_t    data_o,
    output audio_pkg::chan_mask_t ack_o,
    output audio_pkg::chan_mask_t tap_pop_o  [NUM_STAGES+1],
    input  audio_pkg::sample_t    tap_data_i [NUM_STAGES+1],
    input  audio_pkg::chan_mask_t tap_ack_i  [NUM_STAGES+1]
);
    import audio_pkg::*;

    chan_mask_t ack_mux;
    sample_t    data_mux;
    chan_mask_t ack_q;
    sample_t    data_q;

    // Tap k is the output after k stages, same as the rate code
    always_comb begin
        ack_mux  = '0;
        data_mux = '0;
        for (int k = 0; k <= NUM_STAGES; k++) begin
            if (int'(rate_i) == k) begin
                tap_pop_o[k] = pop_i;
                ack_mux      = tap_ack_i[k];
                data_mux     = tap_data_i[k];
            end else begin
                tap_pop_o[k] = '0;  // Unused stages stay quiet
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= '0;
        end else begin
            ack_q <= ack_mux;
        end
    end

    always_ff @(posedge clk) begin
        data_q <= data_mux;
    end

    assign ack_o  = ack_q;
    assign data_o = data_q;

endmodule

`default_nettype wire

// File: rtl/sample_prefetch.sv
`timescale 1ns/1ps
`default_nettype none

module sample_prefetch (
    input  logic                  clk,
    input  logic                  arst_n_i,
    output audio_pkg::chan_mask_t src_pop_o,
    input  audio_pkg::sample_t    src_data_i,
    input  audio_pkg::chan_mask_t src_ack_i,
    input  audio_pkg::chan_mask_t pop_i,
    output audio_pkg::sample_t    data_o,
    output audio_pkg::chan_mask_t ack_o
);
    import audio_pkg::*;

    chan_mask_t full_q;   // Held sample valid
    chan_mask_t req_q;    // Source request outstanding
    chan_mask_t pend_q;   // Consumer waiting
    sample_t    held_q [NUM_CH];

    chan_mask_t avail;
    chan_mask_t want;
    chan_mask_t sel;
    sample_t    out_val;
    chan_mask_t src_pop_q;
    chan_mask_t ack_q;
    sample_t    data_q;

    always_comb begin
        avail   = full_q | src_ack_i;  // Source ack passes straight through
        want    = (pend_q | pop_i) & avail;
        sel     = '0;
        out_val = '0;
        for (int c = 0; c < NUM_CH; c++) begin
            if (want[c] && sel == '0) begin
                sel[c]  = 1'b1;  // Left first, one ack per cycle
                out_val = full_q[c] ? held_q[c] : src_data_i;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            full_q    <= '0;
            req_q     <= '0;
            pend_q    <= '0;
            src_pop_q <= '0;
            ack_q     <= '0;
        end else begin
            src_pop_q <= '0;
            ack_q     <= sel;
            for (int c = 0; c < NUM_CH; c++) begin
                if (sel[c]) begin
                    pend_q[c] <= 1'b0;
                end else if (pop_i[c]) begin
                    pend_q[c] <= 1'b1;
                end
                full_q[c] <= avail[c] & ~sel[c];
                // Fetch again as soon as the slot is empty and nothing is in flight
                if (!(avail[c] && !sel[c]) && !(req_q[c] && !src_ack_i[c])) begin
                    src_pop_q[c] <= 1'b1;
                    req_q[c]     <= 1'b1;
                end else if (src_ack_i[c]) begin
                    req_q[c] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        data_q <= out_val;
        for (int c = 0; c < NUM_CH; c++) begin
            if (src_ack_i[c] && !sel[c]) begin
                held_q[c] <= src_data_i;
            end
        end
    end

    assign src_pop_o = src_pop_q;
    assign ack_o     = ack_q;
    assign data_o    = data_q;

endmodule

`default_nettype wire

// File: rtl/upsample_chain.sv
`timescale 1ns/1ps
`default_nettype none

module upsample_chain #(
    parameter int               NUM_STAGES  = 2,
    parameter audio_pkg::coef_t COEF        = 16'h4000,  // One half
    parameter int               SLOT_CYCLES = 16
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  audio_pkg::rate_e      rate_i,
    output audio_pkg::chan_mask_t src_pop_o,
    input  audio_pkg::sample_t    src_data_i,
    input  audio_pkg::chan_mask_t src_ack_i,
    input  audio_pkg::chan_mask_t pop_i,
    output audio_pkg::sample_t    data_o,
    output audio_pkg::chan_mask_t ack_o
);
    import audio_pkg::*;

    // Tap 0 is the prefetch output, tap k the output of stage k
    chan_mask_t tap_pop    [NUM_STAGES+1];
    sample_t    tap_data   [NUM_STAGES+1];
    chan_mask_t tap_ack    [NUM_STAGES+1];
    chan_mask_t sel_pop    [NUM_STAGES+1];  // From the output selector
    chan_mask_t stg_up_pop [NUM_STAGES];    // From the stage above each tap

    mult_if mult_bus [NUM_STAGES] ();

    sample_prefetch prefetch_i (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .src_pop_o (src_pop_o),
        .src_data_i(src_data_i),
        .src_ack_i (src_ack_i),
        .pop_i     (tap_pop[0]),
        .data_o    (tap_data[0]),
        .ack_o     (tap_ack[0])
    );

    for (genvar g = 0; g < NUM_STAGES; g++) begin : g_stage
        upsample_stage #(.COEF(COEF)) stage_i (
            .clk      (clk),
            .arst_n_i (arst_n_i),
            .up_pop_o (stg_up_pop[g]),
            .up_data_i(tap_data[g]),
            .up_ack_i (tap_ack[g]),
            .pop_i    (tap_pop[g+1]),
            .data_o   (tap_data[g+1]),
            .ack_o    (tap_ack[g+1]),
            .mult     (mult_bus[g])
        );
    end

    // Only one of the two sources is live at the selected rate
    for (genvar k = 0; k < NUM_STAGES; k++) begin : g_tap_pop
        assign tap_pop[k] = sel_pop[k] | stg_up_pop[k];
    end

    assign tap_pop[NUM_STAGES] = sel_pop[NUM_STAGES];  // Nothing above the last stage

    mult_share #(
        .NUM_STAGES (NUM_STAGES),
        .SLOT_CYCLES(SLOT_CYCLES)
    ) mult_share_i (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .out_pop_i(pop_i),
        .mult     (mult_bus)
    );

    rate_output_select #(.NUM_STAGES(NUM_STAGES)) out_sel_i (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .rate_i    (rate_i),
        .pop_i     (pop_i),
        .data_o    (data_o),
        .ack_o     (ack_o),
        .tap_pop_o (sel_pop),
        .tap_data_i(tap_data),
        .tap_ack_i (tap_ack)
    );

endmodule

`default_nettype wire

// File: rtl/upsample_stage.sv
`timescale 1ns/1ps
`default_nettype none

module upsample_stage #(
    parameter audio_pkg::coef_t COEF = 16'h4000
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    output audio_pkg::chan_mask_t up_pop_o,
    input  audio_pkg::sample_t    up_data_i,
    input  audio_pkg::chan_mask_t up_ack_i,
    input  audio_pkg::chan_mask_t pop_i,
    output audio_pkg::sample_t    data_o,
    output audio_pkg::chan_mask_t ack_o,
    mult_if.stage                 mult
);
    import audio_pkg::*;

    localparam int CH_W = $clog2(NUM_CH);

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,  // Upstream request out
        S_WAIT,   // Waiting for grant to issue prev * COEF
        S_MUL1,   // Waiting for grant to issue cur * COEF
        S_MUL2,   // Second product in flight
        S_DRAIN   // Result parked behind the other channel
    } state_e;

    state_e     state_q [NUM_CH];
    chan_mask_t phase_q;  // 1 means the stored sample goes out next
    sample_t    prev_q  [NUM_CH];
    sample_t    cur_q   [NUM_CH];
    sample_t    acc_q   [NUM_CH];
    sample_t    res_q   [NUM_CH];

    chan_mask_t      want;
    logic [CH_W-1:0] issue_ch;
    logic            issue_en;
    logic            issue_last;

    logic            tag_vld_d1, tag_vld_d2;
    logic            tag_last_d1, tag_last_d2;
    logic [CH_W-1:0] tag_ch_d1, tag_ch_d2;

    chan_mask_t odd_hit;
    chan_mask_t first;
    chan_mask_t fin;
    chan_mask_t cand;
    chan_mask_t sel;
    sample_t    val [NUM_CH];
    sample_t    out_val;

    chan_mask_t up_pop_q;
    chan_mask_t ack_q;
    sample_t    data_q;

    // Multiplier port, left channel wins
    always_comb begin
        for (int c = 0; c < NUM_CH; c++) begin
            want[c] = (state_q[c] == S_WAIT) || (state_q[c] == S_MUL1);
        end
        issue_ch = '0;
        for (int c = NUM_CH - 1; c >= 0; c--) begin
            if (want[c]) begin
                issue_ch = CH_W'(c);
            end
        end
        issue_en    = mult.grant & (|want);
        issue_last  = (state_q[issue_ch] == S_MUL1);
        mult.mpcand = '0;
        mult.mplier = '0;
        if (issue_en) begin
            mult.mpcand = issue_last ? cur_q[issue_ch] : prev_q[issue_ch];
            mult.mplier = COEF;
        end
    end

    // Output candidates, one ack per cycle
    always_comb begin
        sel     = '0;
        out_val = '0;
        for (int c = 0; c < NUM_CH; c++) begin
            odd_hit[c] = pop_i[c] & phase_q[c] & (state_q[c] == S_IDLE);
            first[c]   = tag_vld_d2 & ~tag_last_d2 & (tag_ch_d2 == CH_W'(c));
            fin[c]     = tag_vld_d2 & tag_last_d2 & (tag_ch_d2 == CH_W'(c));
            cand[c]    = (state_q[c] == S_DRAIN) | odd_hit[c] | fin[c];
            if (state_q[c] == S_DRAIN) begin
                val[c] = res_q[c];
            end else if (odd_hit[c]) begin
                val[c] = prev_q[c];
            end else begin
                val[c] = acc_q[c] + mult.mprod;  // Interpolated sum
            end
            if (cand[c] && sel == '0) begin
                sel[c]  = 1'b1;
                out_val = val[c];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            phase_q    <= '0;
            up_pop_q   <= '0;
            ack_q      <= '0;
            tag_vld_d1 <= 1'b0;
            tag_vld_d2 <= 1'b0;
            for (int c = 0; c < NUM_CH; c++) begin
                state_q[c] <= S_IDLE;
                prev_q[c]  <= '0;
            end
        end else begin
            up_pop_q   <= '0;
            ack_q      <= sel;
            tag_vld_d1 <= issue_en;
            tag_vld_d2 <= tag_vld_d1;
            for (int c = 0; c < NUM_CH; c++) begin
                case (state_q[c])
                    S_IDLE: begin
                        if (pop_i[c] && !phase_q[c]) begin
                            up_pop_q[c] <= 1'b1;
                            state_q[c]  <= S_FETCH;
                        end else if (odd_hit[c]) begin
                            phase_q[c] <= 1'b0;
                            if (!sel[c]) state_q[c] <= S_DRAIN;
                        end
                    end
                    S_FETCH: if (up_ack_i[c]) state_q[c] <= S_WAIT;
                    S_WAIT:  if (issue_en && issue_ch == CH_W'(c)) state_q[c] <= S_MUL1;
                    S_MUL1:  if (issue_en && issue_ch == CH_W'(c)) state_q[c] <= S_MUL2;
                    S_MUL2: begin
                        if (fin[c]) begin
                            phase_q[c] <= 1'b1;
                            prev_q[c]  <= cur_q[c];  // New sample becomes history
                            state_q[c] <= sel[c] ? S_IDLE : S_DRAIN;
                        end
                    end
                    S_DRAIN: if (sel[c]) state_q[c] <= S_IDLE;
                    default: state_q[c] <= S_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        data_q      <= out_val;
        tag_ch_d1   <= issue_ch;
        tag_ch_d2   <= tag_ch_d1;
        tag_last_d1 <= issue_last;
        tag_last_d2 <= tag_last_d1;
        for (int c = 0; c < NUM_CH; c++) begin
            if (up_ack_i[c] && state_q[c] == S_FETCH) cur_q[c] <= up_data_i;
            if (first[c]) acc_q[c] <= mult.mprod;
            if (cand[c] && !sel[c]) res_q[c] <= val[c];
        end
    end

    assign up_pop_o = up_pop_q;
    assign ack_o    = ack_q;
    assign data_o   = data_q;

endmodule

`default_nettype wire

// File: testbench/tb_upsample_chain.sv
`timescale 1ns/1ps
`default_nettype none

module tb_upsample_chain;
    import audio_pkg::*;

    localparam int    NUM_STAGES  = 2;
    localparam coef_t COEF        = 16'h4000;
    localparam int    SLOT_CYCLES = 16;
    localparam int    LIST_LEN    = 8;
    localparam int    MAX_OUT     = 64;
    localparam int    NUM_ROWS    = 7;
    localparam int    NUM_SETS    = 2;
    localparam int    TIMEOUT     = 2000;

    logic       clk;
    logic       arst_n_i;
    rate_e      rate_i;
    chan_mask_t src_pop_o;
    sample_t    src_data_i;
    chan_mask_t src_ack_i;
    chan_mask_t pop_i;
    sample_t    data_o;
    chan_mask_t ack_o;

    // Stimulus table with one entry per row
    rate_e   row_rate  [NUM_ROWS];
    bit      row_rand  [NUM_ROWS];  // Random sink gaps
    int      row_set   [NUM_ROWS];
    int      row_count [NUM_ROWS];  // Outputs per channel
    int      row_lead  [NUM_ROWS];  // Left outputs before the right channel starts
    sample_t list_tab  [NUM_SETS][NUM_CH][LIST_LEN];
    sample_t exp_tab   [NUM_CH][MAX_OUT];

    logic [31:0]       lfsr_q;
    logic [NUM_CH-1:0] src_busy;
    int                src_delay [NUM_CH];
    int                src_idx   [NUM_CH];
    int                cur_set;
    int                errors;
    int                checks;
    int                rows_done;
    bit                timed_out;

    upsample_chain #(
        .NUM_STAGES (NUM_STAGES),
        .COEF       (COEF),
        .SLOT_CYCLES(SLOT_CYCLES)
    ) dut_i (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .rate_i    (rate_i),
        .src_pop_o (src_pop_o),
        .src_data_i(src_data_i),
        .src_ack_i (src_ack_i),
        .pop_i     (pop_i),
        .data_o    (data_o),
        .ack_o     (ack_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int b = 0; b < n; b++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = (v << 1) | int'(lfsr_q[0]);
        end
        return v;
    endfunction

    // COEF times x in Q1.15 with an arithmetic shift back to sample width
    function automatic sample_t scale(input sample_t x);
        longint p;
        p = longint'(x) * longint'(COEF);
        return sample_t'(p >>> 15);
    endfunction

    // Number of 2x stages behind each output rate
    function automatic int stages_for(input rate_e rate);
        case (rate)
            RATE_96: return 1;
            RATE_48: return 2;
            default: return 0;
        endcase
    endfunction

    task automatic set_row(input int r, input rate_e rate, input bit rnd, input int set,
                           input int count, input int lead);
        row_rate[r]  = rate;
        row_rand[r]  = rnd;
        row_set[r]   = set;
        row_count[r] = count;
        row_lead[r]  = lead;
    endtask

    task automatic load_table();
        list_tab[0][0] = '{24'sd100000, -24'sd200000, 24'sd300000, 24'sd4000,
                           -24'sd5000, 24'sd1234567, -24'sd7654321, 24'sd42};
        list_tab[0][1] = '{-24'sd11, 24'sd65536, -24'sd3000000, 24'sd2999999,
                           24'sd7, -24'sd1, 24'sd500000, -24'sd250000};
        list_tab[1][0] = '{24'sh7fffff, 24'sh800000, 24'sh7fffff, 24'sh123456,
                           24'shdb9754, 24'sh800000, 24'sh800000, 24'sh7fffff};
        list_tab[1][1] = '{24'sh800000, 24'sh7fffff, 24'sh000001, 24'shffffff,
                           24'sh7fffff, 24'sh7fffff, 24'sh400000, 24'shc00000};
        set_row(0, RATE_192, 1'b0, 0, 8, 0);
        set_row(1, RATE_96,  1'b0, 0, 16, 0);
        set_row(2, RATE_48,  1'b0, 1, 32, 0);
        set_row(3, RATE_96,  1'b0, 1, 16, 9);   // Left alone for a stretch
        set_row(4, RATE_192, 1'b1, 0, 8, 0);
        set_row(5, RATE_96,  1'b1, 0, 16, 0);
        set_row(6, RATE_48,  1'b1, 1, 32, 0);
    endtask

    // Each 2x stage emits the interpolated value and then the new sample
    task automatic build_expected(input int r);
        sample_t work [MAX_OUT];
        sample_t next [MAX_OUT];
        sample_t prev;
        int      len;
        for (int c = 0; c < NUM_CH; c++) begin
            for (int i = 0; i < MAX_OUT; i++) begin
                work[i] = (i < LIST_LEN) ? list_tab[row_set[r]][c][i] : '0;
                next[i] = '0;
            end
            len = LIST_LEN;
            for (int s = 0; s < stages_for(row_rate[r]); s++) begin
                prev = '0;
                for (int i = 0; i < len; i++) begin
                    next[2*i]   = scale(prev) + scale(work[i]);
                    next[2*i+1] = work[i];
                    prev        = work[i];
                end
                len  = len * 2;
                work = next;
            end
            exp_tab[c] = work;
        end
    endtask

    // Source answers each fetch after 0 to 7 cycles and serves one channel per cycle
    task automatic serve_source();
        bit served;
        served     = 1'b0;
        src_ack_i  = '0;
        src_data_i = '0;
        for (int c = 0; c < NUM_CH; c++) begin
            if (src_pop_o[c]) begin
                if (src_busy[c]) begin
                    $display("Source fetch on channel %0d before the previous answer", c);
                    errors++;
                end
                src_busy[c]  = 1'b1;
                src_delay[c] = take_bits(3);
            end
        end
        for (int c = 0; c < NUM_CH; c++) begin
            if (src_busy[c] && src_delay[c] == 0 && !served) begin
                src_ack_i[c] = 1'b1;
                src_data_i   = (src_idx[c] < LIST_LEN) ? list_tab[cur_set][c][src_idx[c]] : '0;
                src_idx[c]++;
                src_busy[c]  = 1'b0;
                served       = 1'b1;
            end else if (src_busy[c] && src_delay[c] > 0) begin
                src_delay[c]--;
            end
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;  // Drive and sample just after the edge
        serve_source();
    endtask

    task automatic reset_dut(input int r);
        arst_n_i = 1'b0;
        pop_i    = '0;
        rate_i   = row_rate[r];  // Rate only changes under reset
        cur_set  = row_set[r];
        src_busy = '0;
        for (int c = 0; c < NUM_CH; c++) begin
            src_idx[c]   = 0;
            src_delay[c] = 0;
        end
        for (int i = 0; i < 4; i++) begin
            tick();
            if (ack_o != '0 || src_pop_o != '0) begin
                $display("Outputs active while reset is held in row %0d", r);
                errors++;
            end
        end
        arst_n_i = 1'b1;
    endtask

    // With no sink traffic only the first fetch per channel may appear
    task automatic check_idle(input int r);
        int pops [NUM_CH];
        for (int c = 0; c < NUM_CH; c++) begin
            pops[c] = 0;
        end
        for (int i = 0; i < 12; i++) begin
            tick();
            if (ack_o != '0) begin
                $display("ack_o rose with no request in row %0d", r);
                errors++;
            end
            for (int c = 0; c < NUM_CH; c++) begin
                if (src_pop_o[c]) pops[c]++;
            end
        end
        for (int c = 0; c < NUM_CH; c++) begin
            checks++;
            if (pops[c] != 1) begin
                $display("Mismatch at %0t: row %0d channel %0d fetch count expected 1 got %0d",
                         $time, r, c, pops[c]);
                errors++;
            end
        end
    endtask

    task automatic compare_output(input int r, input int c, input int idx);
        checks++;
        if (data_o !== exp_tab[c][idx]) begin
            $display("Mismatch at %0t: row %0d channel %0d index %0d expected %0d got %0d",
                     $time, r, c, idx, exp_tab[c][idx], data_o);
            errors++;
        end
    endtask

    task automatic run_row(input int r);
        int                got    [NUM_CH];
        int                req    [NUM_CH];
        int                gap    [NUM_CH];
        int                waited [NUM_CH];
        logic [NUM_CH-1:0] outst;
        int                n;
        int                err_start;
        err_start = errors;
        n         = row_count[r];
        outst     = '0;
        for (int c = 0; c < NUM_CH; c++) begin
            got[c]    = 0;
            req[c]    = 0;
            gap[c]    = 0;
            waited[c] = 0;
        end
        while ((got[0] < n || got[1] < n) && !timed_out) begin
            tick();
            pop_i = '0;
            if (ack_o[0] && ack_o[1]) begin
                $display("Both channels acknowledged in the same cycle at %0t", $time);
                errors++;
            end
            for (int c = 0; c < NUM_CH; c++) begin
                if (ack_o[c]) begin
                    if (!outst[c]) begin
                        $display("Acknowledge on channel %0d with no request outstanding", c);
                        errors++;
                    end else begin
                        compare_output(r, c, got[c]);
                        got[c]++;
                        outst[c] = 1'b0;
                        gap[c]   = row_rand[r] ? take_bits(4) : 0;
                    end
                end else if (outst[c]) begin
                    waited[c]++;
                    if (waited[c] > TIMEOUT) begin
                        $display("Timeout: channel %0d waited %0d cycles for an acknowledge",
                                 c, TIMEOUT);
                        errors++;
                        timed_out = 1'b1;
                    end
                end
            end
            for (int c = 0; c < NUM_CH; c++) begin
                if (!outst[c] && req[c] < n && (c == 0 || got[0] >= row_lead[r])) begin
                    if (gap[c] > 0) begin
                        gap[c]--;
                    end else begin
                        pop_i[c]  = 1'b1;
                        outst[c]  = 1'b1;
                        req[c]++;
                        waited[c] = 0;
                    end
                end
            end
        end
        pop_i = '0;
        $display("Row %0d %s sink %s: %0d outputs per channel, %0d errors", r,
                 row_rate[r].name(), row_rand[r] ? "random" : "gap-free", n, errors - err_start);
    endtask

    initial begin
        arst_n_i   = 1'b0;
        rate_i     = RATE_192;
        src_data_i = '0;
        src_ack_i  = '0;
        pop_i      = '0;
        lfsr_q     = 32'h75f7_09d3;
        errors     = 0;
        checks     = 0;
        rows_done  = 0;
        timed_out  = 1'b0;
        load_table();
        for (int r = 0; r < NUM_ROWS && !timed_out; r++) begin
            build_expected(r);
            reset_dut(r);
            check_idle(r);
            run_row(r);
            rows_done++;
        end
        $display("Rows %0d of %0d, checks %0d, errors %0d", rows_done, NUM_ROWS, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
